// ==== project.f ====
hdl/frontendPkg.sv
hdl/decodeStage.sv
hdl/multiPortRam.sv
hdl/instBuffer.sv
hdl/frontendTop.sv
test/tbClock.sv
test/tbFrontend.sv

// ==== Bender.yml ====
package:
  name: frontend

sources:
  - hdl/frontendPkg.sv
  - hdl/decodeStage.sv
  - hdl/multiPortRam.sv
  - hdl/instBuffer.sv
  - hdl/frontendTop.sv
  - target: test
    files:
      - test/tbClock.sv
      - test/tbFrontend.sv

// ==== test/tbFrontend.sv ====
// Front end testbench with random fetch traffic, a reference decoder and a dispatch checker.
`timescale 1ns/1ps

module tbFrontend;

  import frontendPkg::*;

  localparam int FetchWidth    = BundleWidth;
  localparam int DispatchWidth = 2;
  localparam int QueueDepth    = 16;
  localparam int SlotCount     = 2 * FetchWidth;
  // Cycle limits for the waits.
  localparam int ResetTimeout  = 50;
  localparam int StallTimeout  = 300;
  localparam int DrainTimeout  = 200;
  localparam int AcceptTimeout = 50;

  logic                           clk;
  logic                           rst;
  logic                           flush;
  logic                           fetchValid;
  fetchBundle_t                   fetchBundle;
  logic                           fetchReady;
  logic                           dispatchValid;
  logic                           dispatchReady;
  microOp_t                       dispatchGroup [DispatchWidth];
  logic [$clog2(DispatchWidth):0] branchCount;

  // Model state owned by the compare process.
  microOp_t    decQ [$];
  microOp_t    bufQ [$];
  logic        decOcc        = 1'b0;
  logic        stallSeen     = 1'b0;
  int          acceptCount   = 0;
  int          dispatchCount = 0;
  int          pairCount     = 0;
  logic [31:0] lfsrState     = 32'hedc2;

  tbClock u_tbClock (
    .clk_o (clk),
    .rst_o (rst)
  );

  frontendTop #(
    .FetchWidth    (FetchWidth),
    .DispatchWidth (DispatchWidth),
    .QueueDepth    (QueueDepth)
  ) u_frontendTop (
    .clk             (clk),
    .rst_i           (rst),
    .flush_i         (flush),
    .fetchValid_i    (fetchValid),
    .fetchBundle_i   (fetchBundle),
    .fetchReady_o    (fetchReady),
    .dispatchValid_o (dispatchValid),
    .dispatchReady_i (dispatchReady),
    .dispatchGroup_o (dispatchGroup),
    .branchCount_o   (branchCount)
  );

  task automatic abortRun();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
      abortRun();
    end
  endtask

  // Galois LFSR with taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'h8020_0003;
    end
    return next;
  endfunction

  // One LFSR step per bit taken.
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value     = {value[30:0], lfsrState[0]};
      lfsrState = lfsrStep(lfsrState);
    end
    return value;
  endfunction

  function automatic fetchBundle_t randomBundle();
    fetchBundle_t b;
    logic [2:0]   op;
    logic [27:0]  body;
    logic [13:0]  pcWord;
    for (int k = 0; k < FetchWidth; k++) begin
      // Opcodes stay inside the eight defined values.
      op        = 3'(randBits(3));
      body      = 28'(randBits(28));
      b.inst[k] = {1'b0, op, body};
    end
    pcWord  = 14'(randBits(14));
    b.pc    = {pcWord, 2'b00};
    b.valid = FetchWidth'(randBits(FetchWidth));
    return b;
  endfunction

  // Expected micro-ops for one raw instruction and how many it yields.
  function automatic int refDecode(input logic [31:0] inst, input logic [15:0] pc,
                                   output microOp_t first, output microOp_t second);
    opcode_e op;
    int      n;
    op             = opcode_e'(inst[31:28]);
    first          = '0;
    first.pc       = pc;
    first.opcode   = op;
    first.dest     = inst[27:23];
    first.src1     = inst[22:18];
    first.src2     = inst[17:13];
    first.imm      = inst[11:0];
    first.isBranch = (op == OpBranch) || (op == OpJump);
    first.isMem    = (op == OpLoad) || (op == OpStore) || (op == OpLoadPair);
    n              = 1;
    // A paired load becomes two loads on the next register and the next word.
    if (op == OpLoadPair) begin
      first.opcode    = OpLoad;
      n               = 2;
    end
    second          = first;
    second.dest     = first.dest + 5'd1;
    second.imm      = first.imm + 12'd4;
    second.isSecond = 1'b1;
    return n;
  endfunction

  // Handshakes resolve at the next rising edge, so decide them mid cycle.
  always @(negedge clk) begin : compareModel
    microOp_t first;
    microOp_t second;
    int       n;
    int       branches;
    logic     expAccept;
    logic     expReady;
    if (!rst) begin
      expAccept = (bufQ.size() <= QueueDepth - SlotCount);
      expReady  = !decOcc || expAccept;
      checkValue("fetchReady_o", fetchReady, expReady);
      checkValue("dispatchValid_o", dispatchValid, bufQ.size() >= DispatchWidth);
      if (!fetchReady) begin
        stallSeen = 1'b1;
      end
      // Pop the oldest group.
      if (dispatchValid && dispatchReady && !flush) begin
        branches = 0;
        for (int k = 0; k < DispatchWidth; k++) begin
          checkValue($sformatf("dispatchGroup_o[%0d]", k), dispatchGroup[k], bufQ[k]);
          branches  += bufQ[k].isBranch;
          pairCount += bufQ[k].isSecond;
        end
        checkValue("branchCount_o", branchCount, branches);
        repeat (DispatchWidth) void'(bufQ.pop_front());
        dispatchCount += DispatchWidth;
      end
      if (flush) begin
        decQ.delete();
        bufQ.delete();
        decOcc = 1'b0;
      end else begin
        // Decode register drains into the buffer.
        if (decOcc && expAccept) begin
          foreach (decQ[i]) bufQ.push_back(decQ[i]);
          decQ.delete();
          decOcc = 1'b0;
        end
        if (expReady) begin
          decOcc = fetchValid;
          if (fetchValid) begin
            decQ.delete();
            for (int k = 0; k < FetchWidth; k++) begin
              if (fetchBundle.valid[k]) begin
                n = refDecode(fetchBundle.inst[k], fetchBundle.pc + 16'(4 * k), first, second);
                decQ.push_back(first);
                if (n == 2) begin
                  decQ.push_back(second);
                end
              end
            end
            acceptCount++;
          end
        end
      end
    end
  end

  task automatic waitResetRelease();
    int cycles;
    cycles = 0;
    while (rst) begin
      @(posedge clk);
      cycles++;
      if (cycles > ResetTimeout) begin
        $display("Timeout: reset was never released");
        abortRun();
      end
    end
  endtask

  // Random traffic with rare flushes that block dispatch in their cycle.
  task automatic randomTraffic(input int cycles, input logic allowFlush);
    logic doFlush;
    for (int c = 0; c < cycles; c++) begin
      @(posedge clk);
      doFlush        = allowFlush && (randBits(6) == 0);
      fetchBundle   <= randomBundle();
      fetchValid    <= (randBits(2) != 0);
      dispatchReady <= (randBits(2) != 0) && !doFlush;
      flush         <= doFlush;
    end
  endtask

  task automatic waitDrained();
    int cycles;
    cycles = 0;
    while (decOcc || bufQ.size() >= DispatchWidth) begin
      @(posedge clk);
      fetchValid    <= 1'b0;
      dispatchReady <= 1'b1;
      flush         <= 1'b0;
      cycles++;
      if (cycles > DrainTimeout) begin
        $display("Timeout: the instruction buffer did not drain");
        abortRun();
      end
    end
  endtask

  // Stalled dispatch must fill the buffer and stop fetch.
  task automatic holdBackPressure();
    int cycles;
    cycles    = 0;
    stallSeen = 1'b0;
    while (!stallSeen) begin
      @(posedge clk);
      fetchBundle   <= randomBundle();
      fetchValid    <= 1'b1;
      dispatchReady <= 1'b0;
      flush         <= 1'b0;
      cycles++;
      if (cycles > StallTimeout) begin
        $display("Timeout: fetch was never stalled by a full buffer");
        abortRun();
      end
    end
    repeat (6) begin
      @(posedge clk);
      fetchBundle <= randomBundle();
    end
  endtask

  // Fill the buffer, then flush with a bundle on offer.
  task automatic flushWhileBusy();
    repeat (8) begin
      @(posedge clk);
      fetchBundle   <= randomBundle();
      fetchValid    <= 1'b1;
      dispatchReady <= 1'b0;
    end
    @(posedge clk);
    fetchBundle <= randomBundle();
    flush       <= 1'b1;
    @(posedge clk);
    flush         <= 1'b0;
    fetchValid    <= 1'b0;
    dispatchReady <= 1'b1;
  endtask

  // Leave one micro-op behind, which must never be offered.
  task automatic leaveOddLeftover();
    fetchBundle_t b;
    int           cycles;
    int           startCount;
    if (bufQ.size() == 0) begin
      b            = randomBundle();
      b.inst[0]    = {OpAlu, 28'(randBits(28))};
      b.valid      = FetchWidth'(1);
      startCount   = acceptCount;
      cycles       = 0;
      @(posedge clk);
      fetchBundle <= b;
      fetchValid  <= 1'b1;
      while (acceptCount == startCount) begin
        @(posedge clk);
        cycles++;
        if (cycles > AcceptTimeout) begin
          $display("Timeout: the last bundle was never accepted");
          abortRun();
        end
      end
      fetchValid <= 1'b0;
    end
    waitDrained();
    // A lone micro-op never forms a group, even with dispatch ready.
    repeat (8) begin
      @(negedge clk);
      checkValue("dispatchValid_o", dispatchValid, 1'b0);
    end
  endtask

  initial begin
    flush         = 1'b0;
    fetchValid    = 1'b0;
    fetchBundle   = '0;
    dispatchReady = 1'b0;
    waitResetRelease();
    randomTraffic(400, 1'b1);
    holdBackPressure();
    waitDrained();
    flushWhileBusy();
    randomTraffic(200, 1'b0);
    waitDrained();
    leaveOddLeftover();
    // Random traffic must have reached dispatch and a paired load.
    if (dispatchCount == 0 || pairCount == 0) begin
      $display("Traffic did not reach dispatch and a paired load");
      abortRun();
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

// ==== test/tbClock.sv ====
// Testbench clock and reset source, 20 ns period with a synchronous reset pulse.
`timescale 1ns/1ps

module tbClock #(
  parameter int HalfPeriod  = 10,
  parameter int ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_o
);

  // Free running clock.
  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // Reset held for a fixed number of rising edges, released on an edge.
  initial begin
    rst_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

// ==== hdl/frontendTop.sv ====
// Front end top level joining the decode stage to the instruction buffer.
`timescale 1ns/1ps

module frontendTop #(
  parameter int FetchWidth    = frontendPkg::BundleWidth,
  parameter int DispatchWidth = 2,
  parameter int QueueDepth    = 16
) (
  input  logic                           clk,
  input  logic                           rst_i,
  input  logic                           flush_i,
  input  logic                           fetchValid_i,
  input  frontendPkg::fetchBundle_t      fetchBundle_i,
  output logic                           fetchReady_o,
  output logic                           dispatchValid_o,
  input  logic                           dispatchReady_i,
  output frontendPkg::microOp_t          dispatchGroup_o [DispatchWidth],
  output logic [$clog2(DispatchWidth):0] branchCount_o
);

  import frontendPkg::*;

  // Decode output width.
  localparam int SlotCount = 2 * FetchWidth;

  // Decode to buffer.
  logic                 decValid;
  microOp_t             decSlots [SlotCount];
  logic [SlotCount-1:0] decMask;
  logic                 bufAccept;

  decodeStage #(
    .FetchWidth (FetchWidth)
  ) u_decodeStage (
    .clk           (clk),
    .rst_i         (rst_i),
    .flush_i       (flush_i),
    .fetchValid_i  (fetchValid_i),
    .fetchBundle_i (fetchBundle_i),
    .fetchReady_o  (fetchReady_o),
    .bufAccept_i   (bufAccept),
    .decValid_o    (decValid),
    .decSlots_o    (decSlots),
    .decMask_o     (decMask)
  );

  instBuffer #(
    .QueueDepth    (QueueDepth),
    .SlotCount     (SlotCount),
    .DispatchWidth (DispatchWidth)
  ) u_instBuffer (
    .clk             (clk),
    .rst_i           (rst_i),
    .flush_i         (flush_i),
    .decValid_i      (decValid),
    .decSlots_i      (decSlots),
    .decMask_i       (decMask),
    .bufAccept_o     (bufAccept),
    .dispatchValid_o (dispatchValid_o),
    .dispatchReady_i (dispatchReady_i),
    .dispatchGroup_o (dispatchGroup_o),
    .branchCount_o   (branchCount_o)
  );

endmodule

// ==== hdl/instBuffer.sv ====
// Instruction buffer queue that compacts valid decode slots and presents dispatch groups.
`timescale 1ns/1ps

module instBuffer #(
  parameter int QueueDepth    = 16,
  parameter int SlotCount     = 4,
  parameter int DispatchWidth = 2
) (
  input  logic                             clk,
  input  logic                             rst_i,
  input  logic                             flush_i,
  input  logic                             decValid_i,
  input  frontendPkg::microOp_t            decSlots_i [SlotCount],
  input  logic [SlotCount-1:0]             decMask_i,
  output logic                             bufAccept_o,
  output logic                             dispatchValid_o,
  input  logic                             dispatchReady_i,
  output frontendPkg::microOp_t            dispatchGroup_o [DispatchWidth],
  output logic [$clog2(DispatchWidth):0]   branchCount_o
);

  // Pointer, occupancy and per-push widths.
  localparam int AddrWidth   = $clog2(QueueDepth);
  localparam int CountWidth  = $clog2(QueueDepth + 1);
  localparam int PushWidth   = $clog2(SlotCount + 1);
  localparam int BranchWidth = $clog2(DispatchWidth) + 1;

  logic [AddrWidth-1:0]  headPtr;
  logic [AddrWidth-1:0]  tailPtr;
  logic [CountWidth-1:0] count;
  logic [CountWidth-1:0] countNext;
  logic [PushWidth-1:0]  pushCount;
  logic                  push;
  logic                  pop;

  logic [SlotCount-1:0]  wrEn;
  logic [AddrWidth-1:0]  wrAddr [SlotCount];
  logic [AddrWidth-1:0]  rdAddr [DispatchWidth];

  // Room for a full decode register worth of slots.
  assign bufAccept_o     = (count <= CountWidth'(QueueDepth - SlotCount));
  // A group is offered only when complete.
  assign dispatchValid_o = (count >= CountWidth'(DispatchWidth));

  assign push = decValid_i & bufAccept_o & ~flush_i;
  assign pop  = dispatchValid_o & dispatchReady_i;

  // Tail compaction.
  // Each live slot lands after all live slots below it.
  always_comb begin : compactSlots
    logic [PushWidth-1:0] offset;
    offset = '0;
    for (int s = 0; s < SlotCount; s++) begin
      wrEn[s]   = push & decMask_i[s];
      wrAddr[s] = tailPtr + AddrWidth'(offset);
      offset    = offset + PushWidth'(decMask_i[s]);
    end
    pushCount = offset;
  end

  // Head group addresses, oldest first.
  always_comb begin
    for (int r = 0; r < DispatchWidth; r++) begin
      rdAddr[r] = headPtr + AddrWidth'(r);
    end
  end

  // Next occupancy from this cycle's push and pop.
  always_comb begin
    countNext = count;
    if (push) begin
      countNext = countNext + CountWidth'(pushCount);
    end
    if (pop) begin
      countNext = countNext - CountWidth'(DispatchWidth);
    end
  end

  // Pointers wrap on their own since the depth is a power of two.
  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      headPtr <= '0;
      tailPtr <= '0;
      count   <= '0;
    end else begin
      if (push) begin
        tailPtr <= tailPtr + AddrWidth'(pushCount);
      end
      if (pop) begin
        headPtr <= headPtr + AddrWidth'(DispatchWidth);
      end
      count <= countNext;
    end
  end

  // Storage, one write port per decode slot and one read port per dispatch lane.
  multiPortRam #(
    .Depth    (QueueDepth),
    .NumWrite (SlotCount),
    .NumRead  (DispatchWidth)
  ) u_multiPortRam (
    .clk      (clk),
    .wrEn_i   (wrEn),
    .wrAddr_i (wrAddr),
    .wrData_i (decSlots_i),
    .rdAddr_i (rdAddr),
    .rdData_o (dispatchGroup_o)
  );

  // Branches in the head group.
  always_comb begin
    branchCount_o = '0;
    for (int r = 0; r < DispatchWidth; r++) begin
      branchCount_o = branchCount_o + BranchWidth'(dispatchGroup_o[r].isBranch);
    end
  end

endmodule

// ==== hdl/multiPortRam.sv ====
// Micro-op storage array with several synchronous write ports and combinational read ports.
`timescale 1ns/1ps

module multiPortRam #(
  parameter int Depth    = 16,
  parameter int NumWrite = 4,
  parameter int NumRead  = 2
) (
  input  logic                      clk,
  input  logic [NumWrite-1:0]       wrEn_i,
  input  logic [$clog2(Depth)-1:0]  wrAddr_i [NumWrite],
  input  frontendPkg::microOp_t     wrData_i [NumWrite],
  input  logic [$clog2(Depth)-1:0]  rdAddr_i [NumRead],
  output frontendPkg::microOp_t     rdData_o [NumRead]
);

  import frontendPkg::*;

  // Entry array.
  microOp_t mem [Depth];

  // All write ports land on the same edge.
  // Addresses never collide, so port order is irrelevant.
  always_ff @(posedge clk) begin
    for (int w = 0; w < NumWrite; w++) begin
      if (wrEn_i[w]) begin
        mem[wrAddr_i[w]] <= wrData_i[w];
      end
    end
  end

  // Asynchronous read ports.
  // A write is visible in the cycle after its edge.
  always_comb begin
    for (int r = 0; r < NumRead; r++) begin
      rdData_o[r] = mem[rdAddr_i[r]];
    end
  end

endmodule

// ==== hdl/decodeStage.sv ====
// Decode stage that cracks a fetch bundle into registered, valid-masked micro-op slots.
`timescale 1ns/1ps

module decodeStage #(
  parameter int FetchWidth = 2
) (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       flush_i,
  input  logic                       fetchValid_i,
  input  frontendPkg::fetchBundle_t  fetchBundle_i,
  output logic                       fetchReady_o,
  input  logic                       bufAccept_i,
  output logic                       decValid_o,
  output frontendPkg::microOp_t      decSlots_o [2*FetchWidth],
  output logic [2*FetchWidth-1:0]    decMask_o
);

  import frontendPkg::*;

  // Each instruction owns two adjacent slots.
  localparam int SlotCount = 2 * FetchWidth;

  microOp_t             slotsNext [SlotCount];
  logic [SlotCount-1:0] maskNext;
  logic                 loadEn;

  // First slot of an instruction, a paired load becomes a plain load.
  function automatic microOp_t crackFirst(rawInst_t raw, logic [PcWidth-1:0] instPc);
    microOp_t uop;
    uop          = '0;
    uop.pc       = instPc;
    uop.opcode   = raw.opcode;
    uop.dest     = raw.dest;
    uop.src1     = raw.src1;
    uop.src2     = raw.src2;
    uop.imm      = raw.imm;
    case (raw.opcode)
      OpBranch, OpJump: uop.isBranch = 1'b1;
      OpLoad, OpStore:  uop.isMem = 1'b1;
      OpLoadPair: begin
        uop.opcode = OpLoad;
        uop.isMem  = 1'b1;
      end
      default: uop.isMem = 1'b0;
    endcase
    return uop;
  endfunction

  // Second half of a pair.
  // Next register, next word.
  function automatic microOp_t crackSecond(microOp_t first);
    microOp_t uop;
    uop          = first;
    uop.dest     = first.dest + RegWidth'(1);
    uop.imm      = first.imm + ImmWidth'(PairImmOffset);
    uop.isSecond = 1'b1;
    return uop;
  endfunction

  // The register can take a new bundle when empty or draining this cycle.
  assign fetchReady_o = ~decValid_o | bufAccept_i;
  assign loadEn       = fetchValid_i & fetchReady_o & ~flush_i;

  // Crack every instruction of the incoming bundle in parallel.
  always_comb begin : crackBundle
    rawInst_t           raw;
    logic [PcWidth-1:0] instPc;
    for (int k = 0; k < FetchWidth; k++) begin
      raw    = rawInst_t'(fetchBundle_i.inst[k]);
      instPc = fetchBundle_i.pc + PcWidth'(InstBytes * k);
      slotsNext[2*k]   = crackFirst(raw, instPc);
      slotsNext[2*k+1] = crackSecond(slotsNext[2*k]);
      // Odd slot only lives for a paired load.
      maskNext[2*k]    = fetchBundle_i.valid[k];
      maskNext[2*k+1]  = fetchBundle_i.valid[k] & (raw.opcode == OpLoadPair);
    end
  end

  // Occupancy bit.
  // Drops on flush, otherwise follows fetch whenever the register is free.
  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      decValid_o <= 1'b0;
    end else if (fetchReady_o) begin
      decValid_o <= fetchValid_i;
    end
  end

  // Slot mask, held while the buffer refuses.
  always_ff @(posedge clk) begin
    if (rst_i) begin
      decMask_o <= '0;
    end else if (loadEn) begin
      decMask_o <= maskNext;
    end
  end

  // Micro-op payload.
  always_ff @(posedge clk) begin
    if (loadEn) begin
      decSlots_o <= slotsNext;
    end
  end

endmodule

// ==== hdl/frontendPkg.sv ====
// Front end shared definitions for raw instructions, opcodes and decoded micro-ops.
package frontendPkg;

  // Raw instruction size.
  localparam int InstWidth = 32;

  // Program counter size.
  localparam int PcWidth = 16;

  // Architectural register index size.
  localparam int RegWidth = 5;

  // Immediate field size.
  localparam int ImmWidth = 12;

  // Instruction slots carried by one fetch bundle.
  localparam int BundleWidth = 2;

  // Byte distance between consecutive instructions.
  localparam int InstBytes = 4;

  // Address step between the two halves of a paired load.
  localparam int PairImmOffset = 4;

  // Major opcode, held in the top four bits of a raw instruction.
  typedef enum logic [3:0] {
    OpAlu      = 4'h0,
    OpAluImm   = 4'h1,
    OpLoad     = 4'h2,
    OpStore    = 4'h3,
    OpLoadPair = 4'h4,
    OpBranch   = 4'h5,
    OpJump     = 4'h6,
    OpNop      = 4'h7
  } opcode_e;

  // Field overlay of one raw instruction, msb first.
  typedef struct packed {
    opcode_e             opcode;   // Bits 31..28.
    logic [RegWidth-1:0] dest;     // Bits 27..23.
    logic [RegWidth-1:0] src1;     // Bits 22..18.
    logic [RegWidth-1:0] src2;     // Bits 17..13.
    logic                reserved; // Bit 12, ignored by decode.
    logic [ImmWidth-1:0] imm;      // Bits 11..0.
  } rawInst_t;

  // Decoded micro-op as stored in the instruction buffer.
  typedef struct packed {
    logic [PcWidth-1:0]  pc;
    opcode_e             opcode;
    logic [RegWidth-1:0] dest;
    logic [RegWidth-1:0] src1;
    logic [RegWidth-1:0] src2;
    logic [ImmWidth-1:0] imm;
    // Set for branches and jumps.
    logic                isBranch;
    // Set for loads and stores.
    logic                isMem;
    // Marks the second half of a split paired load.
    logic                isSecond;
  } microOp_t;

  // One fetch bundle.
  // Instruction k sits at pc + 4k and is live when valid[k] is set.
  typedef struct packed {
    logic [BundleWidth-1:0][InstWidth-1:0] inst;
    logic [PcWidth-1:0]                    pc;
    logic [BundleWidth-1:0]                valid;
  } fetchBundle_t;

endpackage
